/* dv/riscCore_checker.sv */
`timescale 1ns/10ps

module riscCore_checker import risc_pkg::*; (
	input logic Clock_pin,
	input logic arstN,
	input wbMasterT wbOut,
	input logic wbAck
);

	stbNeedsCyc: assert property (@(posedge Clock_pin) disable iff (!arstN)
		wbOut.stb |-> wbOut.cyc)
		else $error("Wishbone stb is high while cyc is low");

	// Request must not move while the slave is still inserting wait cycles
	holdUntilAck: assert property (@(posedge Clock_pin) disable iff (!arstN)
		(wbOut.stb && !wbAck) |=> ($stable(wbOut.adr) && $stable(wbOut.we) &&
		$stable(wbOut.datW)))
		else $error("Wishbone adr, we or datW changed before ack");

	cycKnown: assert property (@(posedge Clock_pin) disable iff (!arstN)
		!$isunknown(wbOut.cyc))
		else $error("Wishbone cyc is unknown");

endmodule

bind riscCore riscCore_checker uChecker (
	.Clock_pin (Clock_pin),
	.arstN     (arstN),
	.wbOut     (wbOut),
	.wbAck     (wbAck)
);

/* dv/riscTb.sv */
`timescale 1ns/10ps
`include "risc_defines.svh"

module riscTb import risc_pkg::*; ();

	localparam wordT dataBase = 14'h280;
	localparam wordT resBase = 14'h300;
	localparam wordT markerAdr = 14'h3FF;     // Last write of the program

	logic Clock_pin = 1'b0;
	logic arstN;
	logic [`SWITCH_W-1:0] switches;
	logic [`DISPLAY_W-1:0] display;
	wbMasterT wbOut;
	logic wbAck;
	wordT wbDatR;

	wordT mem [1024];
	wordT expAdr [$];
	wordT expDat [$];
	logic [`DISPLAY_W-1:0] expDisp [$];
	int expSw [$];     // Switch value set after this write, or -1
	wordT capAdr [$];
	wordT capDat [$];
	logic [`DISPLAY_W-1:0] capDisp [$];
	wordT cA;
	wordT cD;
	logic [`DISPLAY_W-1:0] cDisp;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit;
	int waitLeft;
	int wrCount = 0;
	int cmpIdx = 0;
	int instrCount = 0;
	logic inXfer = 1'b0;
	logic firstRd = 1'b1;
	logic done = 1'b0;
	wordT pg;
	wordT dp;
	wordT rp;
	statusT refFlags;
	logic [`DISPLAY_W-1:0] refDisp;
	opcodeE aluOps [8] = '{opAdd, opSub, opAddc, opSubc, opNot, opAnd, opOr, opXor};
	opcodeE shOps [4] = '{opSrl, opSra, opRotl, opRotr};
	opcodeE jOp [4] = '{opSub, opAdd, opAdd, opSub};
	wordT jA [4] = '{14'd5, 14'h1FFF, 14'h3FFF, 14'd1};     // Z, N+V, C+Z, C+N
	wordT jB [4] = '{14'd5, 14'd1, 14'd1, 14'd2};
	logic [3:0] conds [9] = '{4'b0000, 4'b1000, 4'b0100, 4'b0010, 4'b0001,
		4'b0111, 4'b1011, 4'b1101, 4'b1110};
	// Operand set per condition, so each flag is seen both set and clear
	int jSel [9] = '{0, 1, 1, 1, 3, 2, 0, 3, 2};

	riscCore UUT (
		.Clock_pin (Clock_pin),
		.arstN     (arstN),
		.switches  (switches),
		.display   (display),
		.wbOut     (wbOut),
		.wbAck     (wbAck),
		.wbDatR    (wbDatR)
	);

	always #20 Clock_pin = ~Clock_pin;
	always @(posedge Clock_pin) cycles++;

	task automatic checkWord(string name, wordT got, wordT exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkDisplay(string name, logic [`DISPLAY_W-1:0] got,
		logic [`DISPLAY_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkIdle();
		checkWord("wbOut.cyc", wordT'(wbOut.cyc), '0);
		checkWord("wbOut.stb", wordT'(wbOut.stb), '0);
		checkWord("wbOut.we", wordT'(wbOut.we), '0);
		checkDisplay("display", display, '0);
	endtask

	// Expected result of one instruction, tracking flags and display like the CPU
	function automatic wordT riscRef(opcodeE op, wordT a, wordT b, logic [3:0] f);
		wordT r;
		wordT bb;
		int sv;
		bb = (op == opAddc || op == opSubc) ? wordT'(f) : b;
		r = a;
		case (op)
			opAdd, opAddc: begin
				r = a + bb;
				sv = int'($signed(a)) + int'($signed(bb));
				refFlags.c = (int'(a) + int'(bb)) > 16383;
				refFlags.v = (sv > 8191) || (sv < -8192);
			end
			opSub, opSubc: begin
				r = a - bb;
				sv = int'($signed(a)) - int'($signed(bb));
				refFlags.c = a < bb;     // Borrow
				refFlags.v = (sv > 8191) || (sv < -8192);
			end
			opNot: r = ~a;
			opAnd: r = a & bb;
			opOr: r = a | bb;
			opXor: r = a ^ bb;
			opSrl: r = a >> f[1:0];
			opSra: repeat (f[1:0]) r = {r[13], r[13:1]};
			opRotl: repeat (f[1:0]) r = {r[12:0], r[13]};
			opRotr: repeat (f[1:0]) r = {r[0], r[13:1]};
			opCpy: r = b;
			opOut: refDisp = a[7:0];
			default: ;
		endcase
		if (op inside {opAdd, opAddc, opSub, opSubc, opNot, opAnd, opOr, opXor}) begin
			refFlags.n = r[13];
			refFlags.z = (r == 0);
		end
		return r;
	endfunction

	function automatic logic condHolds(logic [3:0] cond, statusT s);
		case (cond)
			4'b0000: return 1'b1;
			4'b1000: return s.c;
			4'b0100: return s.n;
			4'b0010: return s.v;
			4'b0001: return s.z;
			4'b0111: return !s.c;
			4'b1011: return !s.n;
			4'b1101: return !s.v;
			4'b1110: return !s.z;
			default: return 1'b0;
		endcase
	endfunction

	task automatic emit(wordT w);
		mem[pg[9:0]] = w;
		pg++;
	endtask

	task automatic emitOp(opcodeE op, logic [3:0] ri, logic [3:0] rj);
		emit({op, ri, rj});
		instrCount++;
	endtask

	// LD Rj from the data area, through R1 = 16 when indexed
	task automatic loadData(logic [3:0] rj, wordT value, logic indexed);
		mem[dp[9:0]] = value;
		emitOp(opLd, indexed ? 4'd1 : 4'd0, rj);
		emit(indexed ? dp - 14'd16 : dp);
		dp++;
	endtask

	task automatic expectWrite(wordT val);
		expAdr.push_back(rp);
		expDat.push_back(val);
		expDisp.push_back(refDisp);
		expSw.push_back(-1);
		rp++;
	endtask

	task automatic storeExpect(logic [3:0] rj, wordT val);
		emitOp(opSt, 4'd0, rj);
		emit(rp);
		expectWrite(val);
	endtask

	task automatic buildProgram();
		opcodeE op;
		wordT a;
		wordT b;
		logic [3:0] f;
		int p;
		int sw;
		logic hit;
		for (int i = 0; i < 1024; i++) begin
			mem[i] = wordT'(i * 13 + (i >> 3)) ^ 14'h2A5;
		end
		pg = '0;
		dp = dataBase;
		rp = resBase;
		refFlags = '0;
		refDisp = '0;
		loadData(4'd1, 14'd16, 1'b0);
		loadData(4'd5, 14'd1, 1'b0);
		for (int k = 0; k < 40; k++) begin
			op = aluOps[$urandom % 8];
			a = wordT'($urandom);
			b = wordT'($urandom);
			f = (op == opAddc || op == opSubc) ? 4'($urandom) : 4'd3;
			loadData(4'd2, a, 1'b1);
			loadData(4'd3, b, 1'b1);
			emitOp(op, 4'd2, f);
			storeExpect(4'd2, riscRef(op, a, b, f));
		end
		for (int s = 0; s < 4; s++) begin
			for (int amt = 0; amt < 4; amt++) begin
				a = wordT'($urandom);
				loadData(4'd2, a, 1'b1);
				emitOp(shOps[s], 4'd2, 4'(amt));
				storeExpect(4'd2, riscRef(shOps[s], a, '0, 4'(amt)));
			end
		end
		for (int i = 0; i < 9; i++) begin
			p = jSel[i];
			loadData(4'd2, jA[p], 1'b1);
			loadData(4'd3, jB[p], 1'b1);
			emitOp(jOp[p], 4'd2, 4'd3);
			void'(riscRef(jOp[p], jA[p], jB[p], 4'd3));
			emitOp(opSrl, 4'd4, 4'd1);     // Flags must survive this
			void'(riscRef(opSrl, '0, '0, 4'd1));
			hit = condHolds(conds[i], refFlags);
			emitOp(opJmp, 4'd0, conds[i]);
			emit(pg + 14'd5);
			emitOp(opSt, 4'd0, 4'd0);      // Fall through stores zero
			emit(rp);
			emitOp(opJmp, 4'd0, 4'd0);
			emit(pg + 14'd3);
			emitOp(opSt, 4'd0, 4'd5);      // Taken path stores one
			emit(rp);
			expectWrite(hit ? 14'd1 : 14'd0);
		end
		for (int k = 0; k < 4; k++) begin
			a = wordT'($urandom);
			loadData(4'd2, a, 1'b1);
			emitOp(opCpy, 4'd6, 4'd2);
			storeExpect(4'd6, riscRef(opCpy, '0, a, 4'd2));
		end
		for (int k = 0; k < 4; k++) begin
			sw = $urandom % 32;
			expSw[expSw.size() - 1] = sw;     // New switches after the previous store
			emitOp(opIn, 4'd7, 4'd0);
			a = riscRef(opIn, wordT'(sw), '0, 4'd0);
			emitOp(opOut, 4'd7, 4'd0);
			void'(riscRef(opOut, a, '0, 4'd0));
			storeExpect(4'd7, a);
		end
		emitOp(opSt, 4'd0, 4'd0);
		emit(markerAdr);
		emitOp(opJmp, 4'd0, 4'd0);
		emit(pg - 14'd1);     // Park on itself
	endtask

	// Wishbone slave with random wait states
	always @(negedge Clock_pin) begin
		wbAck <= 1'b0;
		if (arstN && wbOut.stb && !wbAck) begin
			if (!inXfer) begin
				inXfer = 1'b1;
				waitLeft = $urandom % 4;
				if (firstRd) begin
					firstRd = 1'b0;
					checkWord("wbOut.adr", wbOut.adr, wordT'(`RESET_PC));
				end
			end
			if (waitLeft == 0) begin
				inXfer = 1'b0;
				wbAck <= 1'b1;
				wbDatR <= mem[wbOut.adr[9:0]];
				if (wbOut.we) begin
					if (wbOut.adr < 14'd1024) mem[wbOut.adr[9:0]] = wbOut.datW;
					capAdr.push_back(wbOut.adr);
					capDat.push_back(wbOut.datW);
					capDisp.push_back(display);
					if (wrCount < expSw.size() && expSw[wrCount] >= 0) begin
						switches <= expSw[wrCount][`SWITCH_W-1:0];
					end
					wrCount++;
				end
			end else begin
				waitLeft--;
			end
		end
	end

	always @(posedge Clock_pin) begin
		if (capAdr.size() != 0) begin
			cA = capAdr.pop_front();
			cD = capDat.pop_front();
			cDisp = capDisp.pop_front();
			if (cA == markerAdr) begin
				if (cmpIdx != expAdr.size()) begin
					errors++;
					$display("Only %0d of %0d expected writes arrived before the end marker",
						cmpIdx, expAdr.size());
				end
				done = 1'b1;
			end else if (cmpIdx >= expAdr.size()) begin
				errors++;
				$display("Unexpected write of %h to address %h", cD, cA);
			end else begin
				checkWord("wbOut.adr", cA, expAdr[cmpIdx]);
				checkWord("wbOut.datW", cD, expDat[cmpIdx]);
				checkDisplay("display", cDisp, expDisp[cmpIdx]);
				cmpIdx++;
			end
		end
	end

	initial begin
		void'($urandom(32'h419428df));
		arstN = 1'b0;
		switches = '0;
		wbAck = 1'b0;
		wbDatR = '0;
		buildProgram();
		limit = instrCount * 24 + 100;
		repeat (4) begin
			@(negedge Clock_pin);
			checkIdle();
		end
		arstN = 1'b1;
		@(negedge Clock_pin);
		checkIdle();
		while (!done && cycles < limit) @(posedge Clock_pin);
		if (!done) begin
			errors++;
			$display("Timeout after %0d cycles, the program never wrote the end marker", cycles);
		end
		$display("Checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* flist.f */
+incdir+rtl
rtl/risc_pkg.sv
rtl/riscSequencer.sv
rtl/riscRegisters.sv
rtl/riscAlu.sv
rtl/riscBusMaster.sv
rtl/riscCore.sv
dv/riscCore_checker.sv
dv/riscTb.sv

/* rtl/riscAlu.sv */
`timescale 1ns/10ps
`include "risc_defines.svh"

module riscAlu import risc_pkg::*; (
	input logic Clock_pin,
	input logic arstN,
	input instrT instr,
	input wordT regA,
	input wordT regB,
	input logic aluWe,
	output wordT result,
	output statusT status
);

	wordT opB;
	logic isImm;
	logic [`WORD_W:0] sum;      // Top bit is carry out
	logic [`WORD_W:0] diff;     // Top bit is borrow
	logic [1:0] shAmt;
	wordT rotL;
	wordT rotR;
	logic addOvf;
	logic subOvf;
	logic resNeg;
	logic resZero;

	assign isImm = (instr.opcode == opAddc) || (instr.opcode == opSubc);
	assign opB = isImm ? {{(`WORD_W - `REG_SEL_W){1'b0}}, instr.rj} : regB;
	assign shAmt = instr.rj[1:0];

	assign sum = {1'b0, regA} + {1'b0, opB};
	assign diff = {1'b0, regA} - {1'b0, opB};

	// Bits leaving one end come back in at the other
	assign rotL = (regA << shAmt) | (regA >> (`WORD_W - shAmt));
	assign rotR = (regA >> shAmt) | (regA << (`WORD_W - shAmt));

	// Same operand signs but result sign differs
	assign addOvf = (regA[`WORD_W-1] == opB[`WORD_W-1]) &&
		(sum[`WORD_W-1] != regA[`WORD_W-1]);
	// Operand signs differ and result takes the subtrahend sign
	assign subOvf = (regA[`WORD_W-1] != opB[`WORD_W-1]) &&
		(diff[`WORD_W-1] != regA[`WORD_W-1]);

	always_comb begin
		case (instr.opcode)
			opAdd, opAddc: result = sum[`WORD_W-1:0];
			opSub, opSubc: result = diff[`WORD_W-1:0];
			opNot: result = ~regA;
			opAnd: result = regA & opB;
			opOr: result = regA | opB;
			opXor: result = regA ^ opB;
			opSrl: result = regA >> shAmt;
			opSra: result = wordT'($signed(regA) >>> shAmt);
			opRotl: result = rotL;
			opRotr: result = rotR;
			default: result = regA;
		endcase
	end

	assign resNeg = result[`WORD_W-1];
	assign resZero = (result == '0);     // From the current result

	always_ff @(posedge Clock_pin or negedge arstN) begin
		if (!arstN) begin
			status <= '0;
		end else if (aluWe) begin
			case (instr.opcode)
				opAdd, opAddc: begin
					status.c <= sum[`WORD_W];
					status.n <= resNeg;
					status.v <= addOvf;
					status.z <= resZero;
				end
				opSub, opSubc: begin
					status.c <= diff[`WORD_W];
					status.n <= resNeg;
					status.v <= subOvf;
					status.z <= resZero;
				end
				opNot, opAnd, opOr, opXor: begin
					status.n <= resNeg;     // C and V kept
					status.z <= resZero;
				end
				default: ;
			endcase
		end
	end

endmodule

/* rtl/riscBusMaster.sv */
`timescale 1ns/10ps

module riscBusMaster import risc_pkg::*; (
	input logic Clock_pin,
	input logic arstN,
	input busReqT busReq,
	input logic busStart,
	output logic busDone,
	output wordT busRdata,
	output wbMasterT wbOut,
	input logic wbAck,
	input wordT wbDatR
);

	logic busBusy;
	logic ackSeen;

	assign busBusy = wbOut.cyc;
	assign ackSeen = wbOut.stb && wbAck;     // Slave ends the transfer

	always_ff @(posedge Clock_pin or negedge arstN) begin
		if (!arstN) begin
			wbOut <= '0;
			busDone <= 1'b0;
		end else begin
			busDone <= 1'b0;
			if (busStart && !busBusy) begin
				wbOut.cyc <= 1'b1;
				wbOut.stb <= 1'b1;
				wbOut.we <= busReq.we;
				wbOut.adr <= busReq.adr;
				wbOut.datW <= busReq.datW;
			end else if (ackSeen) begin
				wbOut.cyc <= 1'b0;     // Address and data left as they were
				wbOut.stb <= 1'b0;
				busDone <= 1'b1;
			end
		end
	end

	// Held until the next acknowledged transfer
	always_ff @(posedge Clock_pin) begin
		if (ackSeen) begin
			busRdata <= wbDatR;
		end
	end

endmodule

/* rtl/riscCore.sv */
`timescale 1ns/10ps
`include "risc_defines.svh"

module riscCore import risc_pkg::*; (
	input logic Clock_pin,
	input logic arstN,
	input logic [`SWITCH_W-1:0] switches,
	output logic [`DISPLAY_W-1:0] display,
	output wbMasterT wbOut,
	input logic wbAck,
	input wordT wbDatR
);

	busReqT busReq;
	logic busStart;
	logic busDone;
	wordT busRdata;
	instrT instr;
	logic regWe;
	logic aluWe;
	wbSelE wbSel;
	wordT regA;
	wordT regB;
	wordT aluResult;
	statusT status;

	riscSequencer uSeq (
		.Clock_pin (Clock_pin),
		.arstN     (arstN),
		.busReq    (busReq),
		.busStart  (busStart),
		.busDone   (busDone),
		.busRdata  (busRdata),
		.instr     (instr),
		.regWe     (regWe),
		.aluWe     (aluWe),
		.wbSel     (wbSel),
		.regA      (regA),
		.regB      (regB),
		.status    (status)
	);

	riscRegisters uRegs (
		.Clock_pin (Clock_pin),
		.arstN     (arstN),
		.instr     (instr),
		.regWe     (regWe),
		.wbSel     (wbSel),
		.aluResult (aluResult),
		.busRdata  (busRdata),
		.switches  (switches),
		.regA      (regA),
		.regB      (regB),
		.display   (display)
	);

	riscAlu uAlu (
		.Clock_pin (Clock_pin),
		.arstN     (arstN),
		.instr     (instr),
		.regA      (regA),
		.regB      (regB),
		.aluWe     (aluWe),
		.result    (aluResult),
		.status    (status)
	);

	riscBusMaster uBus (
		.Clock_pin (Clock_pin),
		.arstN     (arstN),
		.busReq    (busReq),
		.busStart  (busStart),
		.busDone   (busDone),
		.busRdata  (busRdata),
		.wbOut     (wbOut),
		.wbAck     (wbAck),
		.wbDatR    (wbDatR)
	);

endmodule

/* rtl/riscRegisters.sv */
`timescale 1ns/10ps
`include "risc_defines.svh"

module riscRegisters import risc_pkg::*; (
	input logic Clock_pin,
	input logic arstN,
	input instrT instr,
	input logic regWe,
	input wbSelE wbSel,
	input wordT aluResult,
	input wordT busRdata,
	input logic [`SWITCH_W-1:0] switches,
	output wordT regA,
	output wordT regB,
	output logic [`DISPLAY_W-1:0] display
);

	wordT regFile [`REG_COUNT];
	wordT wrData;
	logic [`REG_SEL_W-1:0] wrSel;
	logic isOut;

	assign regA = regFile[instr.ri];
	assign regB = regFile[instr.rj];
	assign isOut = (instr.opcode == opOut);
	assign wrSel = (instr.opcode == opLd) ? instr.rj : instr.ri;     // LD targets Rj

	always_comb begin
		case (wbSel)
			wbBus: wrData = busRdata;
			wbSwitch: wrData = {{(`WORD_W - `SWITCH_W){1'b0}}, switches};
			wbRegB: wrData = regB;
			default: wrData = aluResult;
		endcase
	end

	always_ff @(posedge Clock_pin or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
			display <= '0;
		end else if (regWe) begin
			if (isOut) begin
				display <= regA[`DISPLAY_W-1:0];     // Low byte of Ri
			end else begin
				regFile[wrSel] <= wrData;
			end
		end
	end

endmodule

/* rtl/riscSequencer.sv */
`timescale 1ns/10ps
`include "risc_defines.svh"

module riscSequencer import risc_pkg::*; (
	input logic Clock_pin,
	input logic arstN,
	output busReqT busReq,
	output logic busStart,
	input logic busDone,
	input wordT busRdata,
	output instrT instr,
	output logic regWe,
	output logic aluWe,
	output wbSelE wbSel,
	input wordT regA,
	input wordT regB,
	input statusT status
);

	seqStateE state;
	wordT pc;
	instrT ir;
	wordT effAddr;
	logic busIssued;     // Request of this state already sent
	logic needBus;
	logic jumpTaken;
	instrT fetched;
	wordT addrCalc;

	assign instr = ir;
	assign fetched = instrT'(busRdata);
	assign needBus = (state == Fetch) || (state == FetchAddr) || (state == MemAccess);

	// Base word from the bus plus index, R0 as index means no index
	assign addrCalc = busRdata + ((ir.ri == '0) ? wordT'(0) : regA);

	always_comb begin
		case (jumpCondE'(ir.rj))
			jU: jumpTaken = 1'b1;
			jC1: jumpTaken = status.c;
			jN1: jumpTaken = status.n;
			jV1: jumpTaken = status.v;
			jZ1: jumpTaken = status.z;
			jC0: jumpTaken = !status.c;
			jN0: jumpTaken = !status.n;
			jV0: jumpTaken = !status.v;
			jZ0: jumpTaken = !status.z;
			default: jumpTaken = 1'b0;     // Undefined codes fall through
		endcase
	end

	always_comb begin
		busReq.adr = pc;
		busReq.datW = regB;     // ST stores Rj
		busReq.we = 1'b0;
		if (state == MemAccess) begin
			busReq.adr = effAddr;
			busReq.we = (ir.opcode == opSt);
		end
	end

	// Writeback source and strobes per opcode
	always_comb begin
		regWe = 1'b0;
		aluWe = 1'b0;
		case (ir.opcode)
			opLd: wbSel = wbBus;
			opIn: wbSel = wbSwitch;
			opCpy: wbSel = wbRegB;
			default: wbSel = wbAlu;
		endcase
		if (state == MemAccess) begin
			regWe = busDone && (ir.opcode == opLd);
		end
		if (state == Execute) begin
			case (ir.opcode)
				opAdd, opSub, opAddc, opSubc, opNot, opAnd, opOr, opXor: begin
					regWe = 1'b1;
					aluWe = 1'b1;
				end
				opSrl, opSra, opRotl, opRotr, opCpy, opIn, opOut: begin
					regWe = 1'b1;     // OUT goes to the display instead
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge Clock_pin or negedge arstN) begin
		if (!arstN) begin
			state <= Fetch;
			pc <= wordT'(`RESET_PC);
			ir <= '{opcode: opNop, ri: '0, rj: '0};
			busIssued <= 1'b0;
			busStart <= 1'b0;
		end else begin
			busStart <= 1'b0;
			if (needBus && !busIssued) begin
				busStart <= 1'b1;
				busIssued <= 1'b1;
			end
			if (busDone) begin
				busIssued <= 1'b0;
			end
			case (state)
				Fetch: begin
					if (busDone) begin
						state <= Decode;
					end
				end
				Decode: begin
					ir <= fetched;
					pc <= pc + 1'b1;
					if (fetched.opcode == opLd || fetched.opcode == opSt ||
						fetched.opcode == opJmp) begin
						state <= FetchAddr;
					end else begin
						state <= Execute;
					end
				end
				FetchAddr: begin
					if (busDone) begin
						if (ir.opcode == opJmp) begin
							pc <= jumpTaken ? addrCalc : pc + 1'b1;
							state <= Fetch;
						end else begin
							pc <= pc + 1'b1;     // Skip the address word
							state <= MemAccess;
						end
					end
				end
				MemAccess: begin
					if (busDone) begin
						state <= Fetch;
					end
				end
				default: state <= Fetch;     // Execute lasts one cycle
			endcase
		end
	end

	always_ff @(posedge Clock_pin) begin
		if (state == FetchAddr && busDone) begin
			effAddr <= addrCalc;
		end
	end

endmodule

/* rtl/risc_defines.svh */
`ifndef RISC_DEFINES_SVH
`define RISC_DEFINES_SVH

// Datapath and address width
`define WORD_W 14

// Instruction word fields
`define OPCODE_W 6
`define REG_SEL_W 4

`define REG_COUNT 16

// First instruction fetched after reset
`define RESET_PC 0

// Board I/O
`define SWITCH_W 5
`define DISPLAY_W 8

`endif

/* rtl/risc_pkg.sv */
`include "risc_defines.svh"

package risc_pkg;

	typedef logic [`WORD_W-1:0] wordT;

	typedef enum logic [`OPCODE_W-1:0] {
		opLd = 6'd0,
		opSt = 6'd1,
		opCpy = 6'd2,
		opJmp = 6'd4,
		opAdd = 6'd5,
		opSub = 6'd6,
		opAddc = 6'd7,     // Immediate in Rj field
		opSubc = 6'd8,
		opNot = 6'd11,
		opAnd = 6'd12,
		opOr = 6'd13,
		opXor = 6'd14,
		opSrl = 6'd15,
		opSra = 6'd16,
		opRotl = 6'd17,
		opRotr = 6'd18,
		opIn = 6'd27,
		opOut = 6'd28,
		opNop = 6'd29,
		opBubble = 6'd63
	} opcodeE;

	typedef struct packed {
		opcodeE opcode;
		logic [`REG_SEL_W-1:0] ri;
		logic [`REG_SEL_W-1:0] rj;      // Also jump condition or immediate
	} instrT;

	// One-hot on C N V Z, inverted for the "flag clear" forms
	typedef enum logic [3:0] {
		jU = 4'b0000,
		jC1 = 4'b1000,
		jN1 = 4'b0100,
		jV1 = 4'b0010,
		jZ1 = 4'b0001,
		jC0 = 4'b0111,
		jN0 = 4'b1011,
		jV0 = 4'b1101,
		jZ0 = 4'b1110
	} jumpCondE;

	typedef struct packed {
		logic c;
		logic n;
		logic v;
		logic z;
	} statusT;

	typedef enum logic [1:0] {
		wbAlu,
		wbBus,
		wbSwitch,
		wbRegB
	} wbSelE;

	typedef enum logic [2:0] {
		Fetch,
		Decode,
		FetchAddr,
		MemAccess,
		Execute
	} seqStateE;

	typedef struct packed {
		wordT adr;
		wordT datW;
		logic we;
	} busReqT;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wordT adr;
		wordT datW;
	} wbMasterT;

endpackage

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module riscTb -Mdir obj_dir

simOut=$(./obj_dir/VriscTb)
echo "$simOut"

if grep -qx "Testbench passed" <<< "$simOut"; then
	exit 0
else
	exit 1
fi
